//--- Bender.yml
package:
  name: lsu

export_include_dirs:
  - logic

sources:
  - logic/lsu_pkg.sv
  - logic/lsu_agu.sv
  - logic/lsu_ctrl.sv
  - logic/lsu_load_unit.sv
  - logic/lsu_top.sv
  - target: test
    files:
      - verification/lsu_assert.sv
      - verification/tb_clk_gen.sv
      - verification/tb_lsu.sv

//--- filelist.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_agu.sv
logic/lsu_ctrl.sv
logic/lsu_load_unit.sv
logic/lsu_top.sv
verification/lsu_assert.sv
verification/tb_clk_gen.sv
verification/tb_lsu.sv

//--- logic/lsu_agu.sv
// Address generation for one memory instruction, purely combinational
// The immediate is the 12-bit I/S-type field and is sign-extended here
// Byte enables and store data are not meaningful when misaligned is set
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module lsu_agu (
  input  lsu_pkg::lsu_req_t  req_i,
  output lsu_pkg::lsu_ctrl_t ctrl_o
);

  localparam int unsigned ImmExtBits = `LSU_XLEN - `LSU_IMM_BITS;

  logic [`LSU_XLEN-1:0]    addr;
  logic [1:0]              size;
  logic [`LSU_BE_BITS-1:0] be_base;
  logic                    misaligned;

  assign addr = req_i.operand_a +
                {{ImmExtBits{req_i.imm[`LSU_IMM_BITS-1]}}, req_i.imm};

  // ------------------------------------------------------------------
  // Access size: 0 byte, 1 half, 2 word
  // ------------------------------------------------------------------
  always_comb begin
    unique case (req_i.op)
      lsu_pkg::LSU_LB, lsu_pkg::LSU_LBU, lsu_pkg::LSU_SB: size = 2'd0;
      lsu_pkg::LSU_LH, lsu_pkg::LSU_LHU, lsu_pkg::LSU_SH: size = 2'd1;
      default: size = 2'd2;
    endcase
  end

  always_comb begin
    unique case (size)
      2'd0:    be_base = 4'b0001;
      2'd1:    be_base = 4'b0011;
      default: be_base = 4'b1111;
    endcase
  end

  // Half needs bit 0 clear, word needs both low bits clear
  always_comb begin
    misaligned = 1'b0;
    if (size == 2'd1) begin
      misaligned = addr[0];
    end else if (size == 2'd2) begin
      misaligned = |addr[1:0];
    end
  end

  // ------------------------------------------------------------------
  // Decoded request
  // ------------------------------------------------------------------
  assign ctrl_o.op         = req_i.op;
  assign ctrl_o.addr       = addr;
  assign ctrl_o.be         = be_base << addr[1:0];
  // Store data moves up to the addressed byte lane
  assign ctrl_o.wdata      = req_i.wdata << {addr[1:0], 3'b000};
  assign ctrl_o.trans_id   = req_i.trans_id;
  assign ctrl_o.misaligned = misaligned;

endmodule

`default_nettype wire

//--- logic/lsu_ctrl.sv
// Request buffer and control FSM, one instruction in flight at a time
// Stores and misaligned accesses complete here, loads via the load unit
// The result port has no back-pressure; res_valid_o is a one-cycle pulse
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module lsu_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  lsu_pkg::lsu_ctrl_t            agu_i,
  output logic                          mem_req_valid_o,
  input  logic                          mem_req_ready_i,
  output lsu_pkg::mem_req_t             mem_req_o,
  output logic                          ld_issue_o,
  output lsu_pkg::lsu_op_e              ld_op_o,
  output logic [1:0]                    ld_offset_o,
  output logic [`LSU_TRANS_ID_BITS-1:0] ld_trans_id_o,
  input  logic                          ld_done_i,
  input  lsu_pkg::lsu_result_t          ld_result_i,
  output logic                          res_valid_o,
  output lsu_pkg::lsu_result_t          res_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT_LD,
    ST_DONE
  } state_e;

  state_e               state_q, state_d;
  lsu_pkg::lsu_ctrl_t   buf_q;
  lsu_pkg::lsu_result_t local_res;
  logic                 is_store;
  logic                 req_accept;

  assign is_store = buf_q.op inside {lsu_pkg::LSU_SB, lsu_pkg::LSU_SH, lsu_pkg::LSU_SW};

  // Free again in the cycle the result leaves
  assign req_ready_o = (state_q == ST_IDLE) || (state_q == ST_DONE) ||
                       ((state_q == ST_WAIT_LD) && ld_done_i);
  assign req_accept  = req_valid_i && req_ready_o;

  // ------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_ISSUE: begin
        if (mem_req_ready_i) begin
          state_d = is_store ? ST_DONE : ST_WAIT_LD;
        end
      end
      ST_WAIT_LD: if (ld_done_i) state_d = ST_IDLE;
      ST_DONE:    state_d = ST_IDLE;
      default:    state_d = state_q;
    endcase
    // A new request overrides the return to idle
    if (req_accept) begin
      state_d = agu_i.misaligned ? ST_DONE : ST_ISSUE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      buf_q <= agu_i;
    end
  end

  // ------------------------------------------------------------------
  // Memory port and load hand-off
  // ------------------------------------------------------------------
  assign mem_req_valid_o = (state_q == ST_ISSUE);
  assign mem_req_o.addr  = buf_q.addr[`LSU_XLEN-1:2];
  assign mem_req_o.we    = is_store;
  assign mem_req_o.be    = buf_q.be;
  assign mem_req_o.wdata = buf_q.wdata;

  assign ld_issue_o    = mem_req_valid_o && mem_req_ready_i && !is_store;
  assign ld_op_o       = buf_q.op;
  assign ld_offset_o   = buf_q.addr[1:0];
  assign ld_trans_id_o = buf_q.trans_id;

  // Store or exception completion, faulting address goes in data
  assign local_res.trans_id = buf_q.trans_id;
  assign local_res.data     = buf_q.misaligned ? buf_q.addr : '0;
  assign local_res.ex_valid = buf_q.misaligned;
  assign local_res.cause    = !buf_q.misaligned ? '0 :
                              is_store ? `LSU_CAUSE_ST_MISALIGNED : `LSU_CAUSE_LD_MISALIGNED;

  assign res_valid_o = (state_q == ST_DONE) || ((state_q == ST_WAIT_LD) && ld_done_i);
  assign res_o       = (state_q == ST_WAIT_LD) ? ld_result_i : local_res;

endmodule

`default_nettype wire

//--- logic/lsu_defines.svh
// Widths, exception causes and memory depth for the RV32 load/store unit
// Only XLEN 32 is supported; the byte lane logic assumes four byte enables
// Cause codes follow the RISC-V mcause encoding for misaligned accesses

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Datapath
`define LSU_XLEN 32
`define LSU_BE_BITS 4
`define LSU_IMM_BITS 12
`define LSU_TRANS_ID_BITS 3

// Exception causes
`define LSU_CAUSE_BITS 4
`define LSU_CAUSE_LD_MISALIGNED 4'd4
`define LSU_CAUSE_ST_MISALIGNED 4'd6

// Data memory depth in words
`define LSU_MEM_WORDS 64

`endif

//--- logic/lsu_load_unit.sv
// Tracks the single outstanding load and formats the returned word
// Expects exactly one mem_rsp_valid_i per issued load
// Result and done pulse are registered, one cycle after the response
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module lsu_load_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          issue_i,
  input  lsu_pkg::lsu_op_e              op_i,
  input  logic [1:0]                    offset_i,
  input  logic [`LSU_TRANS_ID_BITS-1:0] trans_id_i,
  input  logic                          mem_rsp_valid_i,
  input  logic [`LSU_XLEN-1:0]          mem_rdata_i,
  output logic                          done_o,
  output lsu_pkg::lsu_result_t          result_o
);

  lsu_pkg::lsu_op_e              op_q;
  logic [1:0]                    offset_q;
  logic [`LSU_TRANS_ID_BITS-1:0] trans_id_q;
  logic [`LSU_XLEN-1:0]          shifted;
  logic [`LSU_XLEN-1:0]          ld_data;

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      op_q       <= op_i;
      offset_q   <= offset_i;
      trans_id_q <= trans_id_i;
    end
  end

  // Addressed lane down to bit 0, then extend by op
  assign shifted = mem_rdata_i >> {offset_q, 3'b000};

  always_comb begin
    unique case (op_q)
      lsu_pkg::LSU_LB:  ld_data = {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::LSU_LBU: ld_data = {24'b0, shifted[7:0]};
      lsu_pkg::LSU_LH:  ld_data = {{16{shifted[15]}}, shifted[15:0]};
      lsu_pkg::LSU_LHU: ld_data = {16'b0, shifted[15:0]};
      default:          ld_data = mem_rdata_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_o <= 1'b0;
    end else begin
      done_o <= mem_rsp_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rsp_valid_i) begin
      result_o <= '{trans_id: trans_id_q, data: ld_data, ex_valid: 1'b0, cause: '0};
    end
  end

endmodule

`default_nettype wire

//--- logic/lsu_pkg.sv
// Types shared by the load/store unit and its testbench
// The op enum fills all eight codes of its 3-bit field
`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

  typedef enum logic [2:0] {
    LSU_LB,
    LSU_LBU,
    LSU_LH,
    LSU_LHU,
    LSU_LW,
    LSU_SB,
    LSU_SH,
    LSU_SW
  } lsu_op_e;

  // Issue request, as it arrives from the producer
  typedef struct packed {
    lsu_op_e                         op;
    logic [`LSU_XLEN-1:0]            operand_a;
    logic [`LSU_IMM_BITS-1:0]        imm;
    logic [`LSU_XLEN-1:0]            wdata;
    logic [`LSU_TRANS_ID_BITS-1:0]   trans_id;
  } lsu_req_t;

  // Decoded request, held in the one-entry buffer
  typedef struct packed {
    lsu_op_e                         op;
    logic [`LSU_XLEN-1:0]            addr;
    logic [`LSU_BE_BITS-1:0]         be;
    logic [`LSU_XLEN-1:0]            wdata;   // already in its byte lane
    logic [`LSU_TRANS_ID_BITS-1:0]   trans_id;
    logic                            misaligned;
  } lsu_ctrl_t;

  // Word-addressed data memory request
  typedef struct packed {
    logic [`LSU_XLEN-3:0]            addr;
    logic                            we;
    logic [`LSU_BE_BITS-1:0]         be;
    logic [`LSU_XLEN-1:0]            wdata;
  } mem_req_t;

  typedef struct packed {
    logic [`LSU_TRANS_ID_BITS-1:0]   trans_id;
    logic [`LSU_XLEN-1:0]            data;
    logic                            ex_valid;
    logic [`LSU_CAUSE_BITS-1:0]      cause;
  } lsu_result_t;

endpackage

`default_nettype wire

//--- logic/lsu_top.sv
// Top level of the simplified RV32 load/store unit
// Single data-memory port; loads get exactly one response, stores none
// One instruction in flight; the result port cannot stall
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module lsu_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Issue port
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  lsu_pkg::lsu_req_t    req_i,
  // Data memory
  output logic                 mem_req_valid_o,
  input  logic                 mem_req_ready_i,
  output lsu_pkg::mem_req_t    mem_req_o,
  input  logic                 mem_rsp_valid_i,
  input  logic [`LSU_XLEN-1:0] mem_rdata_i,
  // Result port
  output logic                 res_valid_o,
  output lsu_pkg::lsu_result_t res_o
);

  lsu_pkg::lsu_ctrl_t            agu_ctrl;
  logic                          ld_issue;
  lsu_pkg::lsu_op_e              ld_op;
  logic [1:0]                    ld_offset;
  logic [`LSU_TRANS_ID_BITS-1:0] ld_trans_id;
  logic                          ld_done;
  lsu_pkg::lsu_result_t          ld_result;

  // ------------------------------------------------------------------
  // Datapath around the control
  // ------------------------------------------------------------------
  lsu_agu i_agu (
    .req_i  (req_i),
    .ctrl_o (agu_ctrl)
  );

  lsu_ctrl i_ctrl (
    .clk_i,
    .rst_ni,
    .req_valid_i,
    .req_ready_o,
    .agu_i          (agu_ctrl),
    .mem_req_valid_o,
    .mem_req_ready_i,
    .mem_req_o,
    .ld_issue_o     (ld_issue),
    .ld_op_o        (ld_op),
    .ld_offset_o    (ld_offset),
    .ld_trans_id_o  (ld_trans_id),
    .ld_done_i      (ld_done),
    .ld_result_i    (ld_result),
    .res_valid_o,
    .res_o
  );

  lsu_load_unit i_load_unit (
    .clk_i,
    .rst_ni,
    .issue_i         (ld_issue),
    .op_i            (ld_op),
    .offset_i        (ld_offset),
    .trans_id_i      (ld_trans_id),
    .mem_rsp_valid_i,
    .mem_rdata_i,
    .done_o          (ld_done),
    .result_o        (ld_result)
  );

endmodule

`default_nettype wire

//--- verification/lsu_assert.sv
// Handshake rules of the load/store unit top level, checked out of reset
// Port names match the lsu_top signals so that the bind can use .*
`timescale 1ns/1ns
`default_nettype none

module lsu_assert (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              req_ready_o,
  input logic              mem_req_valid_o,
  input logic              mem_req_ready_i,
  input lsu_pkg::mem_req_t mem_req_o,
  input logic              res_valid_o
);

  // Number of failed checks
  int unsigned fail_count = 0;

  // Stalled memory request keeps valid and payload
  a_mem_req_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o)
  ) else begin
    $error("Memory request changed or dropped while stalled");
    fail_count++;
  end

  // No new instruction while the memory access is pending
  a_busy_while_issuing: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o |-> !req_ready_o
  ) else begin
    $error("Issue port ready while a memory request is pending");
    fail_count++;
  end

  a_result_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    res_valid_o |=> !res_valid_o
  ) else begin
    $error("Result valid held for two cycles");
    fail_count++;
  end

endmodule

bind lsu_top lsu_assert i_lsu_assert (.*);

`default_nettype wire

//--- verification/tb_clk_gen.sv
// Clock and reset source for the testbench
// 100 ns clock period, active-low reset held for the first 4 rising edges
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned HalfPeriod  = 50;
  localparam int unsigned ResetCycles = 4;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/tb_lsu.sv
// Table-driven test of the load/store unit against a random-stall memory model
// The memory model holds 64 words and answers a load one cycle after its handshake
// Each row runs alone; its expected trans_id is the row index modulo 8
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module tb_lsu;

  localparam int unsigned ReadyTimeout  = 20;
  localparam int unsigned ResultTimeout = 60;
  localparam int unsigned MemIdxBits    = $clog2(`LSU_MEM_WORDS);
  localparam logic [3:0]  CauseLd       = 4'd4;
  localparam logic [3:0]  CauseSt       = 4'd6;

  typedef struct packed {
    lsu_pkg::lsu_op_e op;
    logic [31:0]      operand_a;
    logic [11:0]      imm;
    logic [31:0]      wdata;
    logic [31:0]      exp_data;
    logic             exp_ex;
    logic [3:0]       exp_cause;
  } row_t;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  logic                 req_ready;
  lsu_pkg::lsu_req_t    req;
  logic                 mem_req_valid;
  logic                 mem_req_ready = 1'b0;
  lsu_pkg::mem_req_t    mem_req;
  logic                 mem_rsp_valid = 1'b0;
  logic [31:0]          mem_rdata = '0;
  logic                 res_valid;
  lsu_pkg::lsu_result_t res;

  logic [31:0]          mem_words [`LSU_MEM_WORDS];
  logic [31:0]          rand_state = 32'h5dba;
  int unsigned          mem_handshakes = 0;
  int unsigned          errors = 0;
  int unsigned          timeouts = 0;
  row_t                 rows [$];

  tb_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  lsu_top uut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .req_i           (req),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_req_o       (mem_req),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rdata_i     (mem_rdata),
    .res_valid_o     (res_valid),
    .res_o           (res)
  );

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Fill pattern carries the whole word index
  function automatic logic [31:0] fill_word(input int unsigned word_idx);
    return {16'hc0de, word_idx[7:0], ~word_idx[7:0]};
  endfunction

  // ------------------------------------------------------------------
  // Memory model with random ready
  // ------------------------------------------------------------------
  always @(posedge clk) begin : mem_model
    int unsigned           i;
    logic [MemIdxBits-1:0] widx;
    widx = mem_req.addr[MemIdxBits-1:0];
    if (!rst_n) begin
      for (i = 0; i < `LSU_MEM_WORDS; i++) begin
        mem_words[i] <= fill_word(i);
      end
      mem_req_ready <= 1'b0;
      mem_rsp_valid <= 1'b0;
    end else begin
      mem_rsp_valid <= 1'b0;
      if (mem_req_valid && mem_req_ready) begin
        mem_handshakes <= mem_handshakes + 1;
        if (mem_req.we) begin
          for (i = 0; i < 4; i++) begin
            if (mem_req.be[i]) begin
              mem_words[widx][i*8 +: 8] <= mem_req.wdata[i*8 +: 8];
            end
          end
        end else begin
          mem_rsp_valid <= 1'b1;
          mem_rdata     <= mem_words[widx];
        end
      end
      rand_state = next_random(rand_state);
      mem_req_ready <= (rand_state[1:0] != 2'b00);
    end
  end

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic add_row(input lsu_pkg::lsu_op_e op, input logic [31:0] a,
                         input logic [11:0] imm, input logic [31:0] wdata,
                         input logic [31:0] exp_data, input logic exp_ex,
                         input logic [3:0] exp_cause);
    rows.push_back(row_t'{op, a, imm, wdata, exp_data, exp_ex, exp_cause});
  endtask

  // ------------------------------------------------------------------
  // Stimulus table: op, operand_a, imm, wdata, data, exception, cause
  // ------------------------------------------------------------------
  task automatic build_table();
    add_row(lsu_pkg::LSU_SW,  32'h40, 12'h000, 32'hdeadbeef, 32'h0, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LW,  32'h40, 12'h000, 32'h0, 32'hdeadbeef, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LB,  32'h40, 12'h003, 32'h0, 32'hffffffde, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LBU, 32'h48, 12'hff9, 32'h0, 32'h000000be, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LB,  32'h40, 12'h002, 32'h0, 32'hffffffad, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LH,  32'h40, 12'h002, 32'h0, 32'hffffdead, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LHU, 32'h40, 12'h000, 32'h0, 32'h0000beef, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LH,  32'h40, 12'h000, 32'h0, 32'hffffbeef, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_SW,  32'h44, 12'h000, 32'h12347f56, 32'h0, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LB,  32'h44, 12'h001, 32'h0, 32'h0000007f, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LH,  32'h44, 12'h002, 32'h0, 32'h00001234, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LHU, 32'h44, 12'h000, 32'h0, 32'h00007f56, 1'b0, 4'd0);
    // Partial stores replace only their own bytes
    add_row(lsu_pkg::LSU_SW,  32'h48, 12'h000, 32'h11223344, 32'h0, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_SB,  32'h48, 12'h001, 32'hffffffaa, 32'h0, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_SH,  32'h48, 12'h002, 32'h0000bbcc, 32'h0, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LW,  32'h48, 12'h000, 32'h0, 32'hbbccaa44, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_SB,  32'h4c, 12'h003, 32'h00000080, 32'h0, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LW,  32'h4c, 12'h000, 32'h0, 32'h80de13ec, 1'b0, 4'd0);
    // Misaligned accesses report the faulting address
    add_row(lsu_pkg::LSU_LH,  32'h40, 12'h001, 32'h0, 32'h41, 1'b1, CauseLd);
    add_row(lsu_pkg::LSU_LW,  32'h40, 12'h002, 32'h0, 32'h42, 1'b1, CauseLd);
    add_row(lsu_pkg::LSU_LW,  32'h50, 12'hff3, 32'h0, 32'h43, 1'b1, CauseLd);
    add_row(lsu_pkg::LSU_SH,  32'h48, 12'h003, 32'h00005555, 32'h4b, 1'b1, CauseSt);
    add_row(lsu_pkg::LSU_SW,  32'h48, 12'h001, 32'h66666666, 32'h49, 1'b1, CauseSt);
    add_row(lsu_pkg::LSU_LW,  32'h48, 12'h000, 32'h0, 32'hbbccaa44, 1'b0, 4'd0);
    add_row(lsu_pkg::LSU_LB,  32'h4c, 12'h003, 32'h0, 32'hffffff80, 1'b0, 4'd0);
  endtask

  task automatic run_row(input int unsigned idx, output bit ok);
    row_t              row;
    lsu_pkg::lsu_req_t issue;
    int unsigned       hs_before;
    int unsigned       cycles;
    logic [2:0]        exp_id;
    row             = rows[idx];
    exp_id          = idx[2:0];
    issue.op        = row.op;
    issue.operand_a = row.operand_a;
    issue.imm       = row.imm;
    issue.wdata     = row.wdata;
    issue.trans_id  = exp_id;
    hs_before       = mem_handshakes;
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= issue;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < ReadyTimeout) begin
      @(negedge clk);
      ok = req_ready;
      cycles++;
    end
    // Handshake happens on this edge when ready was seen
    @(posedge clk);
    req_valid <= 1'b0;
    if (!ok) begin
      $display("Timeout: row %0d was never accepted by the LSU", idx);
      timeouts++;
    end else begin
      ok     = 1'b0;
      cycles = 0;
      while (!ok && cycles < ResultTimeout) begin
        @(negedge clk);
        ok = res_valid;
        cycles++;
      end
      if (!ok) begin
        $display("Timeout: no result for row %0d", idx);
        timeouts++;
      end else begin
        compare_field("res_o.trans_id", res.trans_id, exp_id);
        compare_field("res_o.data", res.data, row.exp_data);
        compare_field("res_o.ex_valid", res.ex_valid, row.exp_ex);
        compare_field("res_o.cause", res.cause, row.exp_cause);
        compare_field("memory handshakes", mem_handshakes - hs_before, row.exp_ex ? 0 : 1);
      end
    end
  endtask

  initial begin : stimulus
    int unsigned idx;
    bit          ok;
    req_valid = 1'b0;
    req       = '0;
    build_table();
    ok  = 1'b0;
    idx = 0;
    while (!rst_n && idx < ReadyTimeout) begin
      @(posedge clk);
      idx++;
    end
    if (rst_n) begin
      @(negedge clk);
      compare_field("req_ready_o", req_ready, 1'b1);
      compare_field("res_valid_o", res_valid, 1'b0);
      compare_field("mem_req_valid_o", mem_req_valid, 1'b0);
      ok = 1'b1;
    end else begin
      $display("Timeout: reset was never released");
      timeouts++;
    end
    idx = 0;
    while (ok && idx < rows.size()) begin
      run_row(idx, ok);
      idx++;
    end
    $display("Rows run: %0d of %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
             idx, rows.size(), errors, uut.i_lsu_assert.fail_count, timeouts);
    if (errors == 0 && timeouts == 0 && uut.i_lsu_assert.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
